//--- common/rv_core_pkg.sv
/*
 * RV32I integer core package
 * ISA constants, ALU operation encoding, the two views of an
 * instruction word and the records passed between pipeline stages
 */
package rv_core_pkg;

  // Data path and register index widths
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // Supported major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // funct7 for the base encoding and for SUB/SRA/SRAI
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // funct3 of the integer ALU group
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  // Register-register layout
  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } r_type_t;

  // Register-immediate layout
  typedef struct packed {
    logic [11:0]           imm12;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } i_type_t;

  typedef union packed {
    r_type_t r;
    i_type_t i;
  } instr_u;

  // Decoded operation from decode to execute
  typedef struct packed {
    logic                  valid;
    alu_op_e               alu_op;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic                  use_imm;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       rs1_val;
    logic [XLEN-1:0]       rs2_val;
  } dec_op_t;

  // Write-back record
  typedef struct packed {
    logic                  valid;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       data;
  } wb_t;

endpackage

//--- verilog/rv_regfile.sv
/*
 * Integer register file
 * 32 entries, two combinational read ports and one write port
 * x0 is not stored and always reads as zero
 */
`timescale 1ns/1ps

module rv_regfile
  import rv_core_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic [REG_ADDR_W-1:0] i_rs1_addr,
  input  logic [REG_ADDR_W-1:0] i_rs2_addr,
  output logic [XLEN-1:0]       o_rs1_data,
  output logic [XLEN-1:0]       o_rs2_data,
  input  wb_t                   i_wb
);

  // Storage for x1..x31
  logic [XLEN-1:0] regs [1:31];

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb.valid && (i_wb.rd != '0)) begin
      // Writes aimed at x0 are dropped
      regs[i_wb.rd] <= i_wb.data;
    end
  end

  // Asynchronous reads
  assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
  assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

//--- decode/rv_decoder.sv
/*
 * Decode stage
 * Splits the instruction word, maps opcode and funct fields to an ALU
 * operation, reads both operands with write-back bypass and registers
 * the decoded operation for the execute stage
 */
`timescale 1ns/1ps

module rv_decoder
  import rv_core_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic                  i_instr_vld,
  input  instr_u                i_instr,
  output logic [REG_ADDR_W-1:0] o_rs1_addr,
  output logic [REG_ADDR_W-1:0] o_rs2_addr,
  input  logic [XLEN-1:0]       i_rs1_data,
  input  logic [XLEN-1:0]       i_rs2_data,
  input  wb_t                   i_wb,
  output dec_op_t               o_dec
);

  logic            is_op;
  logic            is_op_imm;
  logic [6:0]      funct7;
  logic            legal;
  alu_op_e         alu_op;
  logic [XLEN-1:0] imm_sext;
  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  dec_op_t         dec_d;

  assign is_op     = (i_instr.r.opcode == OPC_OP);
  assign is_op_imm = (i_instr.i.opcode == OPC_OP_IMM);

  // Shift immediates keep funct7 in the same upper seven bits
  assign funct7   = i_instr.r.funct7;
  assign imm_sext = {{(XLEN-12){i_instr.i.imm12[11]}}, i_instr.i.imm12};

  // Register file is read straight from the incoming word
  assign o_rs1_addr = i_instr.r.rs1;
  assign o_rs2_addr = i_instr.r.rs2;

  // Bypass of the write-back landing in the register file this cycle
  assign rs1_val = (i_wb.valid && (i_wb.rd != '0) && (i_wb.rd == i_instr.r.rs1)) ?
                   i_wb.data : i_rs1_data;
  assign rs2_val = (i_wb.valid && (i_wb.rd != '0) && (i_wb.rd == i_instr.r.rs2)) ?
                   i_wb.data : i_rs2_data;

  always_comb begin
    legal  = is_op || is_op_imm;
    alu_op = ALU_ADD;
    case (i_instr.r.funct3)
      F3_ADD: begin
        // ADDI takes any immediate
        if (is_op && (funct7 == F7_ALT)) alu_op = ALU_SUB;
        else if (is_op && (funct7 != F7_BASE)) legal = 1'b0;
      end
      F3_SLL: begin
        alu_op = ALU_SLL;
        if (funct7 != F7_BASE) legal = 1'b0;
      end
      F3_SLT: begin
        alu_op = ALU_SLT;
        if (is_op && (funct7 != F7_BASE)) legal = 1'b0;
      end
      F3_SLTU: begin
        alu_op = ALU_SLTU;
        if (is_op && (funct7 != F7_BASE)) legal = 1'b0;
      end
      F3_XOR: begin
        alu_op = ALU_XOR;
        if (is_op && (funct7 != F7_BASE)) legal = 1'b0;
      end
      F3_SR: begin
        // Shift right kind is picked by funct7 in both formats
        if (funct7 == F7_ALT) alu_op = ALU_SRA;
        else if (funct7 == F7_BASE) alu_op = ALU_SRL;
        else legal = 1'b0;
      end
      F3_OR: begin
        alu_op = ALU_OR;
        if (is_op && (funct7 != F7_BASE)) legal = 1'b0;
      end
      default: begin
        alu_op = ALU_AND;
        if (is_op && (funct7 != F7_BASE)) legal = 1'b0;
      end
    endcase
  end

  always_comb begin
    dec_d.valid   = i_instr_vld && legal;
    dec_d.alu_op  = alu_op;
    dec_d.rd      = i_instr.r.rd;
    dec_d.rs1     = i_instr.r.rs1;
    // No rs2 dependence for immediate ops
    dec_d.rs2     = is_op ? i_instr.r.rs2 : '0;
    dec_d.use_imm = is_op_imm;
    dec_d.imm     = imm_sext;
    dec_d.rs1_val = rs1_val;
    dec_d.rs2_val = rs2_val;
  end

  // Only the valid bit is cleared by reset
  always_ff @(posedge i_clk) begin
    o_dec <= dec_d;
    if (!i_rst_n) begin
      o_dec.valid <= 1'b0;
    end
  end

endmodule

//--- execute/rv_ex_stage.sv
/*
 * Execute stage
 * Forwards the previous result into the operands, runs the integer ALU
 * and registers the write-back record
 */
`timescale 1ns/1ps

module rv_ex_stage
  import rv_core_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_rst_n,
  input  dec_op_t i_dec,
  output wb_t     o_wb
);

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] rs2_fwd;
  logic [XLEN-1:0] op_b;
  logic [4:0]      shamt;
  logic            fwd_rs1;
  logic            fwd_rs2;
  logic [XLEN-1:0] result;

  // Previous instruction's result beats the value read in decode
  assign fwd_rs1 = o_wb.valid && (o_wb.rd != '0) && (o_wb.rd == i_dec.rs1);
  assign fwd_rs2 = o_wb.valid && (o_wb.rd != '0) && (o_wb.rd == i_dec.rs2);

  assign op_a    = fwd_rs1 ? o_wb.data : i_dec.rs1_val;
  assign rs2_fwd = fwd_rs2 ? o_wb.data : i_dec.rs2_val;

  // Second operand is the immediate for OP-IMM
  assign op_b  = i_dec.use_imm ? i_dec.imm : rs2_fwd;
  assign shamt = op_b[4:0];

  always_comb begin
    case (i_dec.alu_op)
      ALU_ADD: begin
        result = op_a + op_b;
      end
      ALU_SUB: begin
        result = op_a - op_b;
      end
      ALU_SLL: begin
        result = op_a << shamt;
      end
      ALU_SLT: begin
        // Signed compare
        result = {{(XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
      end
      ALU_SLTU: begin
        result = {{(XLEN-1){1'b0}}, (op_a < op_b)};
      end
      ALU_XOR: begin
        result = op_a ^ op_b;
      end
      ALU_SRL: begin
        result = op_a >> shamt;
      end
      ALU_SRA: begin
        // Arithmetic shift keeps the sign bit
        result = $signed(op_a) >>> shamt;
      end
      ALU_OR: begin
        result = op_a | op_b;
      end
      ALU_AND: begin
        result = op_a & op_b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

  // rd and data hold their value across idle cycles
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_wb <= '0;
    end else begin
      o_wb.valid <= i_dec.valid;
      if (i_dec.valid) begin
        o_wb.rd   <= i_dec.rd;
        o_wb.data <= result;
      end
    end
  end

endmodule

//--- verilog/rv_int_core.sv
/*
 * RV32I integer core
 * Three-step pipeline for register and immediate ALU instructions
 * Decode reads the register file, execute computes and writes back
 * Latency is two cycles from a valid instruction to its write-back
 */
`timescale 1ns/1ps

module rv_int_core
  import rv_core_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic                  i_instr_vld,
  input  logic [31:0]           i_instr,
  output logic                  o_wb_vld,
  output logic [REG_ADDR_W-1:0] o_wb_rd,
  output logic [XLEN-1:0]       o_wb_data
);

  dec_op_t               dec;
  wb_t                   wb;
  logic [REG_ADDR_W-1:0] rs1_addr;
  logic [REG_ADDR_W-1:0] rs2_addr;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;

  // Producer of decoded operations
  rv_decoder u_decoder (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_instr_vld (i_instr_vld),
    .i_instr     (instr_u'(i_instr)),
    .o_rs1_addr  (rs1_addr),
    .o_rs2_addr  (rs2_addr),
    .i_rs1_data  (rs1_data),
    .i_rs2_data  (rs2_data),
    .i_wb        (wb),
    .o_dec       (dec)
  );

  // Architectural state written by the write-back record
  rv_regfile u_regfile (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_rs1_addr (rs1_addr),
    .i_rs2_addr (rs2_addr),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_wb       (wb)
  );

  // Consumer of decoded operations
  rv_ex_stage u_ex_stage (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_dec   (dec),
    .o_wb    (wb)
  );

  assign o_wb_vld  = wb.valid;
  assign o_wb_rd   = wb.rd;
  assign o_wb_data = wb.data;

endmodule

//--- verif/rv_int_core_sva.sv
/*
 * Assertions for the integer core
 * Quiet write-back port in reset, two-cycle write-back timing
 * and a steady rd while no write-back is valid
 */
`timescale 1ns/1ps

module rv_int_core_sva
  import rv_core_pkg::*;
(
  input logic                  i_clk,
  input logic                  i_rst_n,
  input logic                  i_instr_vld,
  input logic [31:0]           i_instr,
  input logic                  i_wb_vld,
  input logic [REG_ADDR_W-1:0] i_wb_rd
);

  logic [6:0] opc;
  logic [6:0] f7;
  logic [2:0] f3;
  logic       supported;
  logic       issue;

  assign opc = i_instr[6:0];
  assign f3  = i_instr[14:12];
  assign f7  = i_instr[31:25];

  // Legal RV32I ALU encodings
  always_comb begin
    supported = 1'b0;
    if (opc == OPC_OP) begin
      supported = (f7 == F7_BASE) || ((f7 == F7_ALT) && (f3 == F3_ADD || f3 == F3_SR));
    end else if (opc == OPC_OP_IMM) begin
      if (f3 == F3_SLL) supported = (f7 == F7_BASE);
      else if (f3 == F3_SR) supported = (f7 == F7_BASE) || (f7 == F7_ALT);
      else supported = 1'b1;
    end
  end

  assign issue = i_instr_vld && supported;

  a_reset_quiet: assert property (@(posedge i_clk) !i_rst_n |=> !i_wb_vld)
    else $error("write-back valid while in reset");

  a_wb_timing: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_wb_vld == $past(issue, 2))
    else $error("write-back valid does not match the issue two cycles earlier");

  a_rd_steady: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !i_wb_vld |-> $stable(i_wb_rd))
    else $error("write-back rd moved without a valid write-back");

endmodule

bind rv_int_core rv_int_core_sva u_sva (
  .i_clk       (i_clk),
  .i_rst_n     (i_rst_n),
  .i_instr_vld (i_instr_vld),
  .i_instr     (i_instr),
  .i_wb_vld    (o_wb_vld),
  .i_wb_rd     (o_wb_rd)
);

//--- verif/tb_rv_int_core.sv
/*
 * Testbench for the RV32I integer core
 * Directed prologue for reset, forwarding, x0 and illegal words,
 * then seeded random ALU traffic checked against an in-order model
 */
`timescale 1ns/1ps

module tb_rv_int_core
  import rv_core_pkg::*;
();

  logic        clk;
  logic        rst_n;
  logic        instr_vld;
  logic [31:0] instr;
  logic        wb_vld;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;

  integer      seed;
  int          errors;
  int          checks;
  int          cyc;
  logic [31:0] model_regs [0:31];

  // Expected write-backs in issue order
  wb_t         want_q  [$];
  string       name_q  [$];
  int          issue_q [$];

  // Operation tables for the register and immediate forms
  string       reg_name [10] = '{"ADD", "SUB", "SLL", "SLT", "SLTU",
                                 "XOR", "SRL", "SRA", "OR", "AND"};
  logic [2:0]  reg_f3   [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3,
                                 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
  logic [6:0]  reg_f7   [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00,
                                 7'h00, 7'h00, 7'h20, 7'h00, 7'h00};
  string       imm_name [9]  = '{"ADDI", "SLTI", "SLTIU", "XORI", "ORI",
                                 "ANDI", "SLLI", "SRLI", "SRAI"};
  logic [2:0]  imm_f3   [9]  = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6,
                                 3'd7, 3'd1, 3'd5, 3'd5};

  rv_int_core dut0 (
    .i_clk       (clk),
    .i_rst_n     (rst_n),
    .i_instr_vld (instr_vld),
    .i_instr     (instr),
    .o_wb_vld    (wb_vld),
    .o_wb_rd     (wb_rd),
    .o_wb_data   (wb_data)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  function automatic logic [31:0] enc_reg(input int idx, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [4:0] rs2);
    return {reg_f7[idx], rs2, rs1, reg_f3[idx], rd, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_imm(input int idx, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
    logic [11:0] field;
    field = imm;
    // Shift forms carry funct7 in the upper immediate bits
    if (idx == 6 || idx == 7) field[11:5] = 7'h00;
    if (idx == 8) field[11:5] = 7'h20;
    return {field, rs1, imm_f3[idx], rd, OPC_OP_IMM};
  endfunction

  task automatic check_value(input string name, input logic [31:0] want,
                             input logic [31:0] got);
    checks++;
    if (got !== want) begin
      errors++;
      $display("ERR %s expected %h actual %h at %0t", name, want, got, $time);
    end
  endtask

  // RV32I semantics with registers updated in issue order
  task automatic model_issue(input logic vld, input logic [31:0] word, output wb_t want);
    logic [6:0]         opc;
    logic [6:0]         f7;
    logic [2:0]         f3;
    logic [4:0]         rd;
    logic [4:0]         rs1;
    logic [4:0]         rs2;
    logic               is_op;
    logic               is_imm;
    logic               legal;
    logic [31:0]        a;
    logic [31:0]        b;
    logic [31:0]        res;
    logic signed [31:0] sa;
    opc    = word[6:0];
    rd     = word[11:7];
    f3     = word[14:12];
    rs1    = word[19:15];
    rs2    = word[24:20];
    f7     = word[31:25];
    is_op  = (opc == OPC_OP);
    is_imm = (opc == OPC_OP_IMM);
    a      = model_regs[rs1];
    b      = is_op ? model_regs[rs2] : {{20{word[31]}}, word[31:20]};
    sa     = a;
    legal  = is_op || is_imm;
    // Alternate funct7 only exists for SUB and SRA
    if (is_op && !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)))) legal = 1'b0;
    if (is_imm && f3 == 3'd1 && f7 != 7'h00) legal = 1'b0;
    if (is_imm && f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20) legal = 1'b0;
    case (f3)
      3'd0: res = (is_op && f7[5]) ? a - b : a + b;
      3'd1: res = a << b[4:0];
      3'd2: res = {31'b0, $signed(a) < $signed(b)};
      3'd3: res = {31'b0, a < b};
      3'd4: res = a ^ b;
      3'd5: begin
        if (f7[5]) res = sa >>> b[4:0];
        else res = a >> b[4:0];
      end
      3'd6: res = a | b;
      default: res = a & b;
    endcase
    want.valid = vld && legal;
    want.rd    = rd;
    want.data  = res;
    // x0 shows on the port but never holds a value
    if (want.valid && rd != 5'd0) model_regs[rd] = res;
  endtask

  task automatic compare_outputs();
    wb_t   want;
    string name;
    cyc++;
    want = '0;
    name = "no issue";
    // Entry is due two cycles after it was driven
    if (issue_q.size() > 0 && issue_q[0] + 2 == cyc) begin
      want = want_q.pop_front();
      name = name_q.pop_front();
      issue_q.delete(0);
    end
    check_value({name, " vld"}, {31'b0, want.valid}, {31'b0, wb_vld});
    if (want.valid && wb_vld) begin
      check_value({name, " rd"}, {27'b0, want.rd}, {27'b0, wb_rd});
      check_value({name, " data"}, want.data, wb_data);
    end
  endtask

  task automatic run_cycle(input logic vld, input logic [31:0] word, input string name);
    wb_t want;
    @(posedge clk);
    #1;
    compare_outputs();
    model_issue(vld, word, want);
    want_q.push_back(want);
    name_q.push_back(name);
    issue_q.push_back(cyc);
    instr_vld = vld;
    instr     = word;
  endtask

  task automatic directed_tests();
    logic [31:0] word;
    // First instruction after reset sees only zero registers
    run_cycle(1'b1, enc_reg(0, 5'd1, 5'd5, 5'd6), "reset ADD");
    run_cycle(1'b1, enc_imm(0, 5'd1, 5'd0, 12'h123), "setup ADDI");
    // Reads of x1 at distance 1, 2 and 3
    run_cycle(1'b1, enc_reg(0, 5'd2, 5'd1, 5'd1), "fwd d1 ADD");
    run_cycle(1'b1, enc_reg(1, 5'd3, 5'd2, 5'd1), "fwd d1 d2 SUB");
    run_cycle(1'b1, enc_imm(3, 5'd4, 5'd1, 12'h0f0), "fwd d3 XORI");
    // Negative immediate and a full arithmetic shift
    run_cycle(1'b1, enc_imm(0, 5'd5, 5'd3, 12'h800), "sext ADDI");
    run_cycle(1'b1, enc_imm(8, 5'd6, 5'd5, 12'h01f), "shift31 SRAI");
    // x0 takes the write on the port but keeps reading zero
    run_cycle(1'b1, enc_imm(0, 5'd0, 5'd1, 12'h7ff), "x0 write");
    run_cycle(1'b1, enc_reg(0, 5'd7, 5'd0, 5'd0), "x0 read d1");
    run_cycle(1'b0, 32'h0, "idle");
    run_cycle(1'b1, enc_reg(5, 5'd7, 5'd0, 5'd1), "x0 read d3");
    // Illegal words leave x1 untouched
    word = enc_reg(0, 5'd1, 5'd2, 5'd2);
    word[31:25] = 7'h01;
    run_cycle(1'b1, word, "bad funct7");
    run_cycle(1'b1, {12'h555, 5'd2, 3'd2, 5'd1, 7'b0000011}, "bad opcode");
    run_cycle(1'b1, enc_reg(0, 5'd2, 5'd1, 5'd0), "after bad");
    // Every operation once on live values
    for (int i = 0; i < 10; i++) begin
      run_cycle(1'b1, enc_reg(i, 5'(i % 7 + 1), 5'(i % 5 + 1), 5'(i % 3 + 2)),
                {"all ", reg_name[i]});
    end
    for (int i = 0; i < 9; i++) begin
      run_cycle(1'b1, enc_imm(i, 5'(i % 6 + 1), 5'(i % 4 + 2), 12'(i * 291 + 2000)),
                {"all ", imm_name[i]});
    end
  endtask

  task automatic random_cycle();
    integer      rnd;
    integer      rnd2;
    logic [3:0]  sel;
    int          idx;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] word;
    rnd  = $random(seed);
    rnd2 = $random(seed);
    sel  = rnd[3:0];
    // Small register pool so that dependences are frequent
    rd   = {2'b00, rnd[6:4]};
    rs1  = {2'b00, rnd[9:7]};
    rs2  = {2'b00, rnd[12:10]};
    if (sel < 4'd2) begin
      run_cycle(1'b0, rnd2, "rand idle");
    end else if (sel == 4'd2) begin
      if (rnd[13]) begin
        word = rnd2;
        // Steer away from the two supported opcodes
        if (word[6:0] == OPC_OP || word[6:0] == OPC_OP_IMM) word[2] = 1'b1;
        run_cycle(1'b1, word, "rand bad opcode");
      end else begin
        word = enc_reg(5, rd, rs1, rs2);
        word[31:25] = rnd[14] ? 7'h01 : 7'h20;
        run_cycle(1'b1, word, "rand bad funct7");
      end
    end else if (sel < 4'd9) begin
      idx = int'(rnd[19:16]) % 10;
      run_cycle(1'b1, enc_reg(idx, rd, rs1, rs2), {"rand ", reg_name[idx]});
    end else begin
      idx = int'(rnd[19:16]) % 9;
      run_cycle(1'b1, enc_imm(idx, rd, rs1, rnd2[11:0]), {"rand ", imm_name[idx]});
    end
  endtask

  initial begin
    int wait_cnt;
    seed      = 32'h794e171a;
    errors    = 0;
    checks    = 0;
    cyc       = 0;
    rst_n     = 1'b0;
    instr_vld = 1'b0;
    instr     = '0;
    for (int r = 0; r < 32; r++) model_regs[r] = '0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    directed_tests();
    for (int n = 0; n < 400; n++) random_cycle();
    // Idle bus until the last write-backs are seen
    wait_cnt = 0;
    while (issue_q.size() > 0 && wait_cnt < 20) begin
      @(posedge clk);
      #1;
      compare_outputs();
      instr_vld = 1'b0;
      wait_cnt++;
    end
    if (issue_q.size() > 0) begin
      errors++;
      $display("Expected write-backs still pending after 20 idle cycles");
    end
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- list.f
common/rv_core_pkg.sv
verilog/rv_regfile.sv
decode/rv_decoder.sv
execute/rv_ex_stage.sv
verilog/rv_int_core.sv
verif/rv_int_core_sva.sv
verif/tb_rv_int_core.sv

//--- Makefile
# Verilator flow for the RV32I integer core

TOP := tb_rv_int_core

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Testbench failed" sim.log; then exit 1; fi
	@grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
